//--- files.f
verilog/intc_pkg.sv
verilog/prio_enc_function.sv
verilog/irq_capture.sv
verilog/intc_apb_regs.sv
verilog/intc_top.sv
test/intc_assertions.sv
test/intc_tb.sv

//--- run.sh
#!/bin/sh
# Build the interrupt controller testbench with Verilator, run it, and
# decide the result from the simulation output.
verilator --binary --timing --assert --top-module intc_tb -f files.f -o intc_sim \
  && ./obj_dir/intc_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
  && echo "Simulation run: pass" \
  || { echo "Simulation run: failure"; exit 1; }

//--- test/intc_assertions.sv
/* Concurrent assertions on APB response and interrupt line timing,
   bound into the interrupt controller top level. */
`timescale 1ns/10ps

module intc_assertions
  import intc_pkg::*;
#(
  parameter int NUM_IRQ = 16
) (
  input logic               clk,
  input logic               rst,
  input apb_req_t           apb_req,
  input apb_rsp_t           apb_rsp,
  input logic [NUM_IRQ-1:0] masked,
  input logic               irq
);

  // Number of assertion failures seen so far.
  int fail_count = 0;

  // The slave never inserts wait states.
  a_pready_access: assert property (
    @(posedge clk) (apb_req.psel && apb_req.penable) |-> apb_rsp.pready
  ) else begin
    fail_count++;
    $error("pready low in an APB access cycle");
  end

  a_irq_reset: assert property (
    @(posedge clk) rst |=> !irq
  ) else begin
    fail_count++;
    $error("irq high during or right after reset");
  end

  // irq is a one-cycle registered copy of the OR of masked.
  a_irq_follows: assert property (
    @(posedge clk) disable iff (rst) !$past(rst) |-> (irq == $past(|masked))
  ) else begin
    fail_count++;
    $error("irq does not follow the masked vector by one cycle");
  end

endmodule

bind intc_top intc_assertions #(
  .NUM_IRQ (NUM_IRQ)
) u_asrt (
  .clk     (clk),
  .rst     (rst),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .masked  (masked),
  .irq     (irq)
);

//--- test/intc_tb.sv
/* Testbench for the interrupt controller: clock and reset, APB tasks,
   source stimulus, reference model and checks. */
`timescale 1ns/10ps

module intc_tb
  import intc_pkg::*;
;

  localparam int NUM_IRQ      = 16;
  localparam int IDX_W        = $clog2(NUM_IRQ);
  localparam int HALF_PERIOD  = 50;
  localparam int SAMPLE_DELAY = 25;
  localparam int RESET_CYCLES = 16;
  localparam int SEED         = 72;
  // The tests take about 1700 cycles.
  localparam int CYCLE_LIMIT  = 4000;

  logic               clk = 1'b0;
  logic               rst;
  apb_req_t           apb_req;
  apb_rsp_t           apb_rsp;
  logic [NUM_IRQ-1:0] irq_src;
  logic               irq;

  // Reference state.
  logic [NUM_IRQ-1:0] en_m;
  logic [NUM_IRQ-1:0] mode_m;
  logic [NUM_IRQ-1:0] pend_m;
  logic [NUM_IRQ-1:0] src_prev_m;
  logic               irq_m;
  int                 cycle_count = 0;

  intc_top #(
    .NUM_IRQ (NUM_IRQ)
  ) dut (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .irq_src (irq_src),
    .irq     (irq)
  );

  always #HALF_PERIOD clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("FAIL at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // Valid flag in bit 31, highest enabled pending index in the low bits.
  function automatic logic [31:0] expected_claim(input logic [NUM_IRQ-1:0] en,
                                                 input logic [NUM_IRQ-1:0] pend);
    logic [NUM_IRQ-1:0] active;
    logic [31:0]        res;
    active = en & pend;
    res = '0;
    for (int i = 0; i < NUM_IRQ; i++) begin
      if (active[i]) begin
        res[31] = 1'b1;
        res[IDX_W-1:0] = IDX_W'(i);
      end
    end
    return res;
  endfunction

  // Model of enable, mode, pending and irq, stepped on every rising edge.
  always @(posedge clk) begin : ref_model
    logic [NUM_IRQ-1:0] nxt;
    logic               wr;
    logic               clr;
    wr = apb_req.psel && apb_req.penable && apb_req.pwrite;
    for (int i = 0; i < NUM_IRQ; i++) begin
      clr = wr && (apb_req.paddr == REG_CLAIM) && (apb_req.pwdata[7:0] == 8'(i));
      if (mode_m[i]) begin
        nxt[i] = (irq_src[i] && !src_prev_m[i]) || (pend_m[i] && !clr);
      end else begin
        nxt[i] = irq_src[i];
      end
    end
    if (rst) begin
      en_m       <= '0;
      mode_m     <= '0;
      pend_m     <= '0;
      src_prev_m <= '0;
      irq_m      <= 1'b0;
    end else begin
      src_prev_m <= irq_src;
      pend_m     <= nxt;
      irq_m      <= |(pend_m & en_m);
      if (wr && apb_req.paddr == REG_ENABLE) begin
        en_m <= apb_req.pwdata[NUM_IRQ-1:0];
      end
      if (wr && apb_req.paddr == REG_MODE) begin
        mode_m <= apb_req.pwdata[NUM_IRQ-1:0];
      end
    end
  end

  // irq is stable at the falling edge.
  always @(negedge clk) begin
    check_equal(32'(irq), 32'(irq_m), "irq against model");
  end

  task automatic apb_transfer(input logic wr, input logic [ADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] wdata,
                              output logic [DATA_W-1:0] rdata, output logic err);
    @(negedge clk);
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = wr;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(negedge clk);
    apb_req.penable = 1'b1;
    #SAMPLE_DELAY;
    check_equal(32'(apb_rsp.pready), 32'd1, "pready in access cycle");
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           output logic err);
    logic [DATA_W-1:0] unused;
    apb_transfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                          output logic err);
    apb_transfer(1'b0, addr, '0, data, err);
  endtask

  task automatic write_ok(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                          input string msg);
    logic err;
    apb_write(addr, data, err);
    check_equal(32'(err), 32'd0, msg);
  endtask

  task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                            input string msg);
    logic [DATA_W-1:0] data;
    logic              err;
    apb_read(addr, data, err);
    check_equal(32'(err), 32'd0, msg);
    check_equal(data, exp, msg);
  endtask

  task automatic drive_sources(input logic [NUM_IRQ-1:0] value);
    @(negedge clk);
    irq_src = value;
  endtask

  initial begin
    logic [DATA_W-1:0]  rdata;
    logic               err;
    logic [NUM_IRQ-1:0] pattern;
    logic [NUM_IRQ-1:0] mask;
    void'($urandom(SEED));
    rst     = 1'b1;
    irq_src = '0;
    apb_req = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst = 1'b0;

    $display("Reset values");
    read_check(REG_ENABLE, 32'h0, "ENABLE after reset");
    read_check(REG_MODE, 32'h0, "MODE after reset");
    read_check(REG_PENDING, 32'h0, "PENDING after reset");
    read_check(REG_CLAIM, 32'h0, "CLAIM after reset");
    check_equal(32'(irq), 32'd0, "irq after reset");

    $display("Level mode, all sources enabled");
    write_ok(REG_MODE, 32'h0, "MODE write");
    write_ok(REG_ENABLE, 32'h0000_FFFF, "ENABLE write");
    for (int n = 0; n < 200; n++) begin
      pattern = NUM_IRQ'($urandom);
      drive_sources(pattern);
      read_check(REG_PENDING, 32'(pattern), "level pending");
      read_check(REG_CLAIM, expected_claim('1, pattern), "level claim");
    end

    $display("Random enable mask");
    mask = (NUM_IRQ'($urandom) & 16'h7FFE) | 16'h8000;
    write_ok(REG_ENABLE, 32'(mask), "ENABLE mask write");
    for (int n = 0; n < 20; n++) begin
      pattern = NUM_IRQ'($urandom);
      drive_sources(pattern);
      read_check(REG_CLAIM, expected_claim(mask, pattern), "masked claim");
      check_equal(32'(irq), 32'(|(mask & pattern)), "irq with mask");
    end
    drive_sources('0);
    repeat (3) @(negedge clk);
    // Source 0 is masked off and must not raise irq.
    drive_sources(16'h0001);
    repeat (3) @(negedge clk);
    check_equal(32'(irq), 32'd0, "irq from disabled source");
    read_check(REG_CLAIM, 32'h0, "claim from disabled source");
    drive_sources('0);
    repeat (3) @(negedge clk);
    drive_sources(16'h8000);
    @(negedge clk);
    check_equal(32'(irq), 32'd0, "irq one cycle after source rise");
    @(negedge clk);
    check_equal(32'(irq), 32'd1, "irq two cycles after source rise");

    $display("Edge mode and claim");
    drive_sources('0);
    repeat (3) @(negedge clk);
    write_ok(REG_MODE, 32'h0000_FFFF, "MODE edge write");
    write_ok(REG_ENABLE, 32'h0000_FFFF, "ENABLE all write");
    drive_sources(16'h0020);
    drive_sources(16'h0000);
    drive_sources(16'h0200);
    drive_sources(16'h0000);
    read_check(REG_PENDING, 32'h0000_0220, "edge pending held");
    read_check(REG_CLAIM, 32'h8000_0009, "edge claim highest");
    write_ok(REG_CLAIM, 32'd9, "claim write 9");
    read_check(REG_PENDING, 32'h0000_0020, "pending after claim 9");
    read_check(REG_CLAIM, 32'h8000_0005, "claim after clearing 9");
    check_equal(32'(irq), 32'd1, "irq with source 5 pending");
    write_ok(REG_CLAIM, 32'd5, "claim write 5");
    check_equal(32'(irq), 32'd1, "irq right after last claim");
    @(negedge clk);
    check_equal(32'(irq), 32'd0, "irq one cycle after last claim");
    read_check(REG_PENDING, 32'h0, "pending after all claims");

    $display("Slave errors");
    apb_read(8'h20, rdata, err);
    check_equal(32'(err), 32'd1, "pslverr on unmapped read");
    apb_write(8'h20, $urandom, err);
    check_equal(32'(err), 32'd1, "pslverr on unmapped write");
    // Differs from the current ENABLE and MODE values, so any aliasing shows up.
    apb_write(REG_PENDING, 32'h0000_5A5A, err);
    check_equal(32'(err), 32'd1, "pslverr on PENDING write");
    read_check(REG_ENABLE, 32'(en_m), "ENABLE after bad writes");
    read_check(REG_MODE, 32'(mode_m), "MODE after bad writes");
    read_check(REG_PENDING, 32'(pend_m), "PENDING after bad writes");

    if (dut.u_asrt.fail_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("SOME TESTS FAILED");
      $fatal(1, "assertion failures: %0d", dut.u_asrt.fail_count);
    end
  end

endmodule

//--- verilog/intc_apb_regs.sv
/* APB register slave for the interrupt controller: enable and mode
   registers, pending and claim reads, claim-write clear, irq output. */
`timescale 1ns/10ps

module intc_apb_regs
  import intc_pkg::*;
#(
  parameter int NUM_IRQ = 16
) (
  input  logic                       clk,
  input  logic                       rst,
  input  apb_req_t                   apb_req,
  output apb_rsp_t                   apb_rsp,
  input  logic [NUM_IRQ-1:0]         pending,
  input  logic [$clog2(NUM_IRQ)-1:0] enc_addr,
  output logic [NUM_IRQ-1:0]         masked,
  output logic [NUM_IRQ-1:0]         mode,
  output irq_clear_t                 clear,
  output logic                       irq
);

  localparam int IDX_W = $clog2(NUM_IRQ);

  intc_reg_e          reg_sel;
  logic               access;
  logic               mapped;
  logic               bad_acc;
  logic               wr_en;
  logic [NUM_IRQ-1:0] enable_q;
  logic [NUM_IRQ-1:0] mode_q;
  logic [DATA_W-1:0]  rd_data;
  logic               irq_q;

  assign reg_sel = intc_reg_e'(apb_req.paddr);
  assign access  = apb_req.psel & apb_req.penable;

  always_comb begin
    case (reg_sel)
      REG_ENABLE, REG_MODE, REG_PENDING, REG_CLAIM: mapped = 1'b1;
      default:                                      mapped = 1'b0;
    endcase
  end

  // PENDING is read-only, so a write there is an error too.
  assign bad_acc = ~mapped | (apb_req.pwrite & (reg_sel == REG_PENDING));
  assign wr_en   = access & apb_req.pwrite & ~bad_acc;

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q <= '0;
      mode_q   <= '0;
    end else if (wr_en) begin
      if (reg_sel == REG_ENABLE) begin
        enable_q <= apb_req.pwdata[NUM_IRQ-1:0];
      end
      if (reg_sel == REG_MODE) begin
        mode_q <= apb_req.pwdata[NUM_IRQ-1:0];
      end
    end
  end

  // A claim write drives the clear for its access cycle only.
  assign clear.valid = wr_en & (reg_sel == REG_CLAIM);
  assign clear.id    = apb_req.pwdata[IRQ_ID_W-1:0];

  assign masked = pending & enable_q;
  assign mode   = mode_q;

  // Read mux from the current register state.
  always_comb begin
    rd_data = '0;
    if (apb_req.psel && !apb_req.pwrite) begin
      case (reg_sel)
        REG_ENABLE:  rd_data = DATA_W'(enable_q);
        REG_MODE:    rd_data = DATA_W'(mode_q);
        REG_PENDING: rd_data = DATA_W'(pending);
        REG_CLAIM: begin
          rd_data[DATA_W-1]  = |masked;
          rd_data[IDX_W-1:0] = enc_addr;
        end
        default:     rd_data = '0;
      endcase
    end
  end

  assign apb_rsp.prdata  = rd_data;
  assign apb_rsp.pready  = 1'b1;
  assign apb_rsp.pslverr = access & bad_acc;

  // The interrupt line lags the masked vector by one cycle.
  always_ff @(posedge clk) begin
    if (rst) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= |masked;
    end
  end

  assign irq = irq_q;

endmodule

//--- verilog/intc_pkg.sv
/* Interrupt controller package: bus widths, register map, APB request and
   response structs, and the claim-clear struct. */
package intc_pkg;

  // APB data and address widths.
  localparam int DATA_W = 32;
  localparam int ADDR_W = 8;

  // Wide enough to name any of up to 256 sources.
  localparam int IRQ_ID_W = 8;

  // Register offsets on the APB address bus.
  typedef enum logic [ADDR_W-1:0] {
    REG_ENABLE  = 8'h00,
    REG_MODE    = 8'h04,
    REG_PENDING = 8'h08,
    REG_CLAIM   = 8'h0C
  } intc_reg_e;

  // Request from the bus master.
  typedef struct packed {
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] pwdata;
  } apb_req_t;

  // Response from the slave.
  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
    logic              pslverr;
  } apb_rsp_t;

  // One-cycle clear of an edge-mode pending bit, named by source ID.
  typedef struct packed {
    logic                valid;
    logic [IRQ_ID_W-1:0] id;
  } irq_clear_t;

endpackage

//--- verilog/intc_top.sv
/* Interrupt controller top level: source capture, APB registers and
   priority encoder. */
`timescale 1ns/10ps

module intc_top
  import intc_pkg::*;
#(
  parameter int NUM_IRQ = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  apb_req_t           apb_req,
  output apb_rsp_t           apb_rsp,
  input  logic [NUM_IRQ-1:0] irq_src,
  output logic               irq
);

  localparam int ENC_W = $clog2(NUM_IRQ);

  logic [NUM_IRQ-1:0] pending;
  logic [NUM_IRQ-1:0] mode;
  logic [NUM_IRQ-1:0] masked;
  logic [ENC_W-1:0]   enc_addr;
  irq_clear_t         clear;

  irq_capture #(
    .NUM_IRQ (NUM_IRQ)
  ) u_capture (
    .clk     (clk),
    .rst     (rst),
    .irq_src (irq_src),
    .mode    (mode),
    .clear   (clear),
    .pending (pending)
  );

  intc_apb_regs #(
    .NUM_IRQ (NUM_IRQ)
  ) u_regs (
    .clk      (clk),
    .rst      (rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .pending  (pending),
    .enc_addr (enc_addr),
    .masked   (masked),
    .mode     (mode),
    .clear    (clear),
    .irq      (irq)
  );

  // Highest-numbered enabled pending source becomes the claim ID.
  prio_enc_function #(
    .W (NUM_IRQ)
  ) u_enc (
    .req      (masked),
    .enc_addr (enc_addr)
  );

endmodule

//--- verilog/irq_capture.sv
/* Interrupt source capture: rising-edge detection and per-source pending
   bits, with level or edge behaviour and clear by ID. */
`timescale 1ns/10ps

module irq_capture
  import intc_pkg::*;
#(
  parameter int NUM_IRQ = 16
) (
  input  logic               clk,
  input  logic               rst,
  input  logic [NUM_IRQ-1:0] irq_src,
  input  logic [NUM_IRQ-1:0] mode,
  input  irq_clear_t         clear,
  output logic [NUM_IRQ-1:0] pending
);

  logic [NUM_IRQ-1:0] src_q;
  logic [NUM_IRQ-1:0] rise;
  logic [NUM_IRQ-1:0] clr_hit;
  logic [NUM_IRQ-1:0] pending_next;

  // Source was low last cycle and is high now.
  assign rise = irq_src & ~src_q;

  for (genvar i = 0; i < NUM_IRQ; i++) begin : g_src
    assign clr_hit[i] = clear.valid && (clear.id == IRQ_ID_W'(i));

    // Edge mode holds the bit until claimed; a new edge beats the clear.
    // Level mode just follows the source and ignores clears.
    always_comb begin
      if (mode[i]) begin
        pending_next[i] = rise[i] | (pending[i] & ~clr_hit[i]);
      end else begin
        pending_next[i] = irq_src[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      src_q   <= '0;
      pending <= '0;
    end else begin
      src_q   <= irq_src;
      pending <= pending_next;
    end
  end

endmodule

//--- verilog/prio_enc_function.sv
/* Priority encoder returning the index of the highest set request bit,
   with its recursive split finder. */
`timescale 1ns/10ps

module prio_enc_function #(
  parameter int W = 16
) (
  input  logic [W-1:0]         req,
  output logic [$clog2(W)-1:0] enc_addr
);

  localparam int AW    = $clog2(W);
  localparam int PAIRS = W / 2;

  logic [PAIRS-1:0]         pair_valid;
  logic [PAIRS-1:0][AW-1:0] pair_addr;
  logic                     top_found;
  logic [AW-1:0]            top_addr;

  // First level works on pairs; the odd bit of each pair wins.
  for (genvar i = 0; i < PAIRS; i++) begin : g_pair
    assign pair_valid[i] = req[2*i+1] | req[2*i];
    assign pair_addr[i]  = req[2*i+1] ? AW'(2*i+1) : AW'(2*i);
  end

  prio_enc_finder #(
    .WIDTH (PAIRS),
    .AW    (AW)
  ) u_finder (
    .valid      (pair_valid),
    .addr       (pair_addr),
    .found      (top_found),
    .found_addr (top_addr)
  );

  // An empty request reports index 0.
  assign enc_addr = top_found ? top_addr : '0;

endmodule

module prio_enc_finder #(
  parameter int WIDTH = 8,
  parameter int AW    = 4
) (
  input  logic [WIDTH-1:0]         valid,
  input  logic [WIDTH-1:0][AW-1:0] addr,
  output logic                     found,
  output logic [AW-1:0]            found_addr
);

  if (WIDTH == 1) begin : g_leaf
    assign found      = valid[0];
    assign found_addr = addr[0];
  end else begin : g_split
    localparam int HALF = WIDTH / 2;

    logic          hi_found;
    logic          lo_found;
    logic [AW-1:0] hi_addr;
    logic [AW-1:0] lo_addr;

    prio_enc_finder #(
      .WIDTH (WIDTH - HALF),
      .AW    (AW)
    ) u_hi (
      .valid      (valid[WIDTH-1:HALF]),
      .addr       (addr[WIDTH-1:HALF]),
      .found      (hi_found),
      .found_addr (hi_addr)
    );

    prio_enc_finder #(
      .WIDTH (HALF),
      .AW    (AW)
    ) u_lo (
      .valid      (valid[HALF-1:0]),
      .addr       (addr[HALF-1:0]),
      .found      (lo_found),
      .found_addr (lo_addr)
    );

    // The upper half always beats the lower half.
    assign found      = hi_found | lo_found;
    assign found_addr = hi_found ? hi_addr : lo_addr;
  end

endmodule
